/* logic/lc4_pkg.sv */
// LC4 dual-issue core shared definitions
// word, register select and NZP types, lane and register counts, reset PC
// opcode and sub-operation encodings of the supported groups
// decode, issue and write-stage records
package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [2:0]  nzp_t;         // {n, z, p}

    localparam int    NUM_LANES = 2;    // lane 0 is A (older), lane 1 is B
    localparam int    NUM_REGS  = 8;
    localparam word_t RESET_PC  = 16'h8200;

    // primary opcodes, insn[15:12]
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LOGIC = 4'b0101;
    localparam logic [3:0] OPC_CONST = 4'b1001;

    // arithmetic sub-operations, insn[5:3] with insn[5] low
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_MUL = 3'b001;
    localparam logic [2:0] SUB_SUB = 3'b010;

    // logic sub-operations, insn[5:3] with insn[5] low
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_NOT = 3'b001;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    // one decoded instruction sitting in a decode slot
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        reg_sel_t rs;
        logic     rs_re;
        reg_sel_t rt;
        logic     rt_re;
        reg_sel_t rd;
        logic     rd_we;                // low for NOP, unsupported or empty slot
    } decoded_t;

    // what one lane latches into its X register
    typedef struct packed {
        decoded_t dec;
        word_t    rs_val;               // register file read, write-through applied
        word_t    rt_val;
    } issue_t;

    // W stage record, feeds bypass, register file write and retire trace
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     we;
        reg_sel_t wsel;
        word_t    data;
        nzp_t     nzp;
    } wb_t;

endpackage

/* logic/lc4_alu.sv */
// LC4 execute unit for the arithmetic, logic and CONST groups
// immediate sign extension and NZP derivation from the result
`timescale 1ns/1ps

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_rs_val,
    input  lc4_pkg::word_t i_rt_val,
    output lc4_pkg::word_t o_result,
    output lc4_pkg::nzp_t  o_nzp
);

    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm9;
    logic [2:0]     sub_op;

    assign imm5   = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm9   = {{7{i_insn[8]}}, i_insn[8:0]};
    assign sub_op = i_insn[5:3];

    always_comb begin
        o_result = '0;                  // anything unsupported yields zero
        case (i_insn[15:12])
            lc4_pkg::OPC_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_val + imm5;     // ADD immediate
                end else begin
                    case (sub_op)
                        lc4_pkg::SUB_ADD: o_result = i_rs_val + i_rt_val;
                        lc4_pkg::SUB_MUL: o_result = i_rs_val * i_rt_val;
                        lc4_pkg::SUB_SUB: o_result = i_rs_val - i_rt_val;
                        default:          o_result = '0;    // DIV not implemented
                    endcase
                end
            end
            lc4_pkg::OPC_LOGIC: begin
                if (i_insn[5]) begin
                    o_result = i_rs_val & imm5;     // AND immediate
                end else begin
                    case (sub_op)
                        lc4_pkg::SUB_AND: o_result = i_rs_val & i_rt_val;
                        lc4_pkg::SUB_NOT: o_result = ~i_rs_val;
                        lc4_pkg::SUB_OR:  o_result = i_rs_val | i_rt_val;
                        lc4_pkg::SUB_XOR: o_result = i_rs_val ^ i_rt_val;
                        default:          o_result = '0;
                    endcase
                end
            end
            lc4_pkg::OPC_CONST: o_result = imm9;
            default:            o_result = '0;
        endcase
    end

    // condition code from the signed result
    always_comb begin
        if (o_result[15]) begin
            o_nzp = 3'b100;
        end else if (o_result == '0) begin
            o_nzp = 3'b010;
        end else begin
            o_nzp = 3'b001;
        end
    end

endmodule

/* logic/lc4_issue.sv */
// fetch PC and two-slot decode register
// per-slot decoder and register file read selects
// pair split when slot B reads what slot A writes
`timescale 1ns/1ps

module lc4_issue (
    input  logic                                             gwe,
    input  logic                                             i_rst,
    input  lc4_pkg::word_t                                   i_insn_a,
    input  lc4_pkg::word_t                                   i_insn_b,
    input  lc4_pkg::word_t   [lc4_pkg::NUM_LANES-1:0][1:0]   i_rd_vals,
    output lc4_pkg::word_t                                   o_cur_pc,
    output lc4_pkg::reg_sel_t [lc4_pkg::NUM_LANES-1:0][1:0]  o_rd_sel,
    output lc4_pkg::issue_t  [lc4_pkg::NUM_LANES-1:0]        o_issue
);

    lc4_pkg::word_t                            pc_q;
    logic           [lc4_pkg::NUM_LANES-1:0]   slot_valid;     // bit 0 is slot A
    lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]   slot_pc;
    lc4_pkg::word_t [lc4_pkg::NUM_LANES-1:0]   slot_insn;
    lc4_pkg::decoded_t [lc4_pkg::NUM_LANES-1:0] dec;
    logic                                      b_reads_a;
    logic                                      split;

    function automatic lc4_pkg::decoded_t decode(
        input logic           valid,
        input lc4_pkg::word_t pc,
        input lc4_pkg::word_t insn
    );
        lc4_pkg::decoded_t d;
        logic is_arith;
        logic is_logic;
        logic is_const;
        logic supported;
        logic uses_rt;
        is_arith  = (insn[15:12] == lc4_pkg::OPC_ARITH);
        is_logic  = (insn[15:12] == lc4_pkg::OPC_LOGIC);
        is_const  = (insn[15:12] == lc4_pkg::OPC_CONST);
        supported = (is_arith && (insn[5] || insn[5:3] == lc4_pkg::SUB_ADD
                                          || insn[5:3] == lc4_pkg::SUB_MUL
                                          || insn[5:3] == lc4_pkg::SUB_SUB))
                    || is_logic || is_const;
        // register-register forms except NOT read rt
        uses_rt   = !insn[5] && (is_arith || (is_logic && insn[5:3] != lc4_pkg::SUB_NOT));
        d.valid   = valid;
        d.pc      = pc;
        d.insn    = insn;
        d.rs      = insn[8:6];
        d.rt      = insn[2:0];
        d.rd      = insn[11:9];
        d.rs_re   = valid && supported && !is_const;
        d.rt_re   = valid && supported && uses_rt;
        d.rd_we   = valid && supported;
        return d;
    endfunction

    always_comb begin
        for (int l = 0; l < lc4_pkg::NUM_LANES; l++) begin
            dec[l]         = decode(slot_valid[l], slot_pc[l], slot_insn[l]);
            o_rd_sel[l][0] = dec[l].rs;
            o_rd_sel[l][1] = dec[l].rt;
        end
    end

    // read-enables already carry slot B's valid
    assign b_reads_a = (dec[1].rs_re && dec[1].rs == dec[0].rd)
                    || (dec[1].rt_re && dec[1].rt == dec[0].rd);
    assign split     = dec[0].rd_we && b_reads_a;

    always_comb begin
        for (int l = 0; l < lc4_pkg::NUM_LANES; l++) begin
            o_issue[l].dec    = dec[l];
            o_issue[l].rs_val = i_rd_vals[l][0];
            o_issue[l].rt_val = i_rd_vals[l][1];
        end
        if (split) begin
            o_issue[1] = '0;            // slot B waits a cycle and lane B gets a bubble
        end
    end

    assign o_cur_pc = pc_q;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q       <= lc4_pkg::RESET_PC;
            slot_valid <= '0;
        end else if (split) begin
            pc_q       <= pc_q + 16'd1;
            slot_valid <= {1'b1, slot_valid[1]};
        end else begin
            pc_q       <= pc_q + 16'd2;
            slot_valid <= '1;
        end
    end

    always_ff @(posedge gwe) begin
        if (split) begin
            slot_pc[0]   <= slot_pc[1];     // held B becomes the older slot
            slot_insn[0] <= slot_insn[1];
            slot_pc[1]   <= pc_q;
            slot_insn[1] <= i_insn_a;
        end else begin
            slot_pc[0]   <= pc_q;
            slot_insn[0] <= i_insn_a;
            slot_pc[1]   <= pc_q + 16'd1;
            slot_insn[1] <= i_insn_b;
        end
    end

    a_no_pair_raw: assert property (@(posedge gwe) disable iff (i_rst)
        (o_issue[1].dec.valid && o_issue[0].dec.rd_we) |->
            !((o_issue[1].dec.rs_re && o_issue[1].dec.rs == o_issue[0].dec.rd) ||
              (o_issue[1].dec.rt_re && o_issue[1].dec.rt == o_issue[0].dec.rd)));

endmodule

/* logic/lc4_lane.sv */
// one execute lane: X register, operand bypass from both W records,
// ALU and the W register that forms the retire record
`timescale 1ns/1ps

module lc4_lane (
    input  logic                                  gwe,
    input  logic                                  i_rst,
    input  lc4_pkg::issue_t                       i_issue,
    input  lc4_pkg::wb_t [lc4_pkg::NUM_LANES-1:0] i_wb_all,
    output lc4_pkg::wb_t                          o_wb
);

    lc4_pkg::issue_t x_q;
    lc4_pkg::word_t  rs_fwd;
    lc4_pkg::word_t  rt_fwd;
    lc4_pkg::word_t  alu_result;
    lc4_pkg::nzp_t   alu_nzp;
    lc4_pkg::wb_t    w_d;
    lc4_pkg::wb_t    w_q;

    // higher lane index is younger, so lane B overrides lane A
    function automatic lc4_pkg::word_t bypass(
        input lc4_pkg::reg_sel_t                     sel,
        input lc4_pkg::word_t                        rf_val,
        input lc4_pkg::wb_t [lc4_pkg::NUM_LANES-1:0] wbs
    );
        lc4_pkg::word_t val;
        val = rf_val;
        for (int l = 0; l < lc4_pkg::NUM_LANES; l++) begin
            if (wbs[l].we && wbs[l].wsel == sel) begin
                val = wbs[l].data;
            end
        end
        return val;
    endfunction

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            x_q.dec.valid <= 1'b0;
            x_q.dec.rd_we <= 1'b0;
        end else begin
            x_q <= i_issue;
        end
    end

    assign rs_fwd = bypass(x_q.dec.rs, x_q.rs_val, i_wb_all);
    assign rt_fwd = bypass(x_q.dec.rt, x_q.rt_val, i_wb_all);

    lc4_alu u_alu (
        .i_insn   (x_q.dec.insn),
        .i_rs_val (rs_fwd),
        .i_rt_val (rt_fwd),
        .o_result (alu_result),
        .o_nzp    (alu_nzp)
    );

    always_comb begin
        w_d.valid = x_q.dec.valid;
        w_d.pc    = x_q.dec.pc;
        w_d.insn  = x_q.dec.insn;
        w_d.we    = x_q.dec.rd_we;
        w_d.wsel  = x_q.dec.rd;
        w_d.data  = alu_result;
        w_d.nzp   = alu_nzp;
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            w_q.valid <= 1'b0;
            w_q.we    <= 1'b0;
        end else begin
            w_q <= w_d;
        end
    end

    assign o_wb = w_q;

    // a write in W traces back to a writing issue two edges earlier
    a_we_from_issue: assert property (@(posedge gwe) disable iff (i_rst)
        o_wb.we |-> (o_wb.valid && $past(i_issue.dec.rd_we, 2)));

endmodule

/* logic/lc4_regfile.sv */
// eight-entry register file, one write port per lane
// four read ports with write-through, lane B wins on a shared destination
`timescale 1ns/1ps

module lc4_regfile (
    input  logic                                               gwe,
    input  logic                                               i_rst,
    input  lc4_pkg::reg_sel_t [lc4_pkg::NUM_LANES-1:0][1:0]    i_rd_sel,
    input  lc4_pkg::wb_t      [lc4_pkg::NUM_LANES-1:0]         i_wb_all,
    output lc4_pkg::word_t    [lc4_pkg::NUM_LANES-1:0][1:0]    o_rd_vals
);

    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    // later loop pass is the younger lane and takes the final NBA
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int r = 0; r < lc4_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < lc4_pkg::NUM_LANES; w++) begin
                if (i_wb_all[w].we) begin
                    regs[i_wb_all[w].wsel] <= i_wb_all[w].data;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < lc4_pkg::NUM_LANES; l++) begin
            for (int p = 0; p < 2; p++) begin
                o_rd_vals[l][p] = regs[i_rd_sel[l][p]];
                for (int w = 0; w < lc4_pkg::NUM_LANES; w++) begin
                    if (i_wb_all[w].we && i_wb_all[w].wsel == i_rd_sel[l][p]) begin
                        o_rd_vals[l][p] = i_wb_all[w].data;   // write-through
                    end
                end
            end
        end
    end

    for (genvar w = 0; w < lc4_pkg::NUM_LANES; w++) begin : g_chk
        a_write_valid: assert property (@(posedge gwe) disable iff (i_rst)
            i_wb_all[w].we |-> i_wb_all[w].valid);
    end

endmodule

/* logic/lc4_core.sv */
// two-lane in-order LC4 core top level
// issue unit, execute lanes in a generate loop, dual-write register file
// W records go to bypass, register writes and the retire trace
`timescale 1ns/1ps

module lc4_core (
    input  logic                                  gwe,
    input  logic                                  i_rst,
    input  lc4_pkg::word_t                        i_insn_a,     // imem at o_cur_pc
    input  lc4_pkg::word_t                        i_insn_b,     // imem at o_cur_pc + 1
    output lc4_pkg::word_t                        o_cur_pc,
    output lc4_pkg::wb_t [lc4_pkg::NUM_LANES-1:0] o_retire
);

    lc4_pkg::reg_sel_t [lc4_pkg::NUM_LANES-1:0][1:0] rd_sel;
    lc4_pkg::word_t    [lc4_pkg::NUM_LANES-1:0][1:0] rd_vals;
    lc4_pkg::issue_t   [lc4_pkg::NUM_LANES-1:0]      issue;
    wire lc4_pkg::wb_t [lc4_pkg::NUM_LANES-1:0]      wb_all;   // one driver per lane

    lc4_issue u_issue (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_insn_a  (i_insn_a),
        .i_insn_b  (i_insn_b),
        .i_rd_vals (rd_vals),
        .o_cur_pc  (o_cur_pc),
        .o_rd_sel  (rd_sel),
        .o_issue   (issue)
    );

    for (genvar l = 0; l < lc4_pkg::NUM_LANES; l++) begin : g_lane
        lc4_lane u_lane (
            .gwe      (gwe),
            .i_rst    (i_rst),
            .i_issue  (issue[l]),
            .i_wb_all (wb_all),
            .o_wb     (wb_all[l])
        );
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rd_sel  (rd_sel),
        .i_wb_all  (wb_all),
        .o_rd_vals (rd_vals)
    );

    assign o_retire = wb_all;

endmodule

/* tb/tb_clock.sv */
// testbench clock, 100 ns period
// reset held high for the first three rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic o_gwe,
    output logic o_rst
);

    initial begin
        o_gwe = 1'b0;
        forever #50 o_gwe = ~o_gwe;
    end

    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_gwe);
        o_rst <= 1'b0;
    end

endmodule

/* tb/lc4_model.svh */
// reference LC4 ISA model for the kept instruction groups
// write decision, source reads, result, condition code and a 32-bit xorshift
`ifndef LC4_MODEL_SVH
`define LC4_MODEL_SVH

// true when the encoding writes a register
function automatic logic model_writes(input logic [15:0] insn);
    case (insn[15:12])
        4'h1:    return insn[5] || (insn[5:3] != 3'b011);  // DIV excluded
        4'h5:    return 1'b1;
        4'h9:    return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// true when the encoding reads register r as a source
function automatic logic model_reads(input logic [15:0] insn, input logic [2:0] r);
    logic rs_hit;
    logic rt_hit;
    rs_hit = (insn[8:6] == r);
    rt_hit = (insn[2:0] == r);
    case (insn[15:12])
        4'h1: begin
            if (insn[5]) return rs_hit;
            if (insn[4:3] == 2'd3) return 1'b0;     // DIV is not executed
            return rs_hit || rt_hit;
        end
        4'h5: begin
            if (insn[5] || insn[4:3] == 2'd1) return rs_hit;
            return rs_hit || rt_hit;
        end
        default: return 1'b0;
    endcase
endfunction

function automatic logic [15:0] model_result(
    input logic [15:0] insn,
    input logic [15:0] a,
    input logic [15:0] b
);
    logic [15:0] imm5;
    imm5 = {{11{insn[4]}}, insn[4:0]};
    if (insn[15:12] == 4'h9) return {{7{insn[8]}}, insn[8:0]};
    if (insn[15:12] == 4'h1) begin
        if (insn[5]) return a + imm5;
        case (insn[4:3])
            2'd0:    return a + b;
            2'd1:    return a * b;
            default: return a - b;
        endcase
    end
    if (insn[5]) return a & imm5;
    case (insn[4:3])
        2'd0:    return a & b;
        2'd1:    return ~a;
        2'd2:    return a | b;
        default: return a ^ b;
    endcase
endfunction

function automatic logic [2:0] model_nzp(input logic [15:0] v);
    if ($signed(v) < 0) return 3'b100;
    if (v == 16'h0) return 3'b010;
    return 3'b001;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* tb/lc4_core_tb.sv */
// testbench for the two-lane LC4 core
// instruction memory, stimulus table with model expectations, retire checks
`timescale 1ns/1ps

module lc4_core_tb;

    localparam int MAX_ROWS  = 512;
    localparam int IMEM_SIZE = 512;
    localparam int NUM_TESTS = 5;

    `include "lc4_model.svh"

    logic                  gwe;
    logic                  rst_init;
    logic                  rst_q = 1'b1;
    logic                  i_rst;
    lc4_pkg::word_t        insn_a;
    lc4_pkg::word_t        insn_b;
    lc4_pkg::word_t        cur_pc;
    lc4_pkg::wb_t [1:0]    retire;
    lc4_pkg::word_t        imem [IMEM_SIZE];

    // stimulus table and model expectations
    logic [15:0] stim_insn [MAX_ROWS];
    logic        exp_we    [MAX_ROWS];
    logic [2:0]  exp_rd    [MAX_ROWS];
    logic [15:0] exp_data  [MAX_ROWS];
    logic [2:0]  exp_nzp   [MAX_ROWS];
    logic        exp_lane  [MAX_ROWS];
    int          test_first [NUM_TESTS];
    int          test_len   [NUM_TESTS];
    string       test_name  [NUM_TESTS];
    int          num_rows    = 0;
    int          cycles      = 0;
    int          cycle_limit = 100000;
    int          checks      = 0;
    int          errors      = 0;
    int          test_errors = 0;

    tb_clock u_clk (.o_gwe(gwe), .o_rst(rst_init));

    assign i_rst = rst_init | rst_q;
    // same-cycle instruction memory where empty locations read as NOP
    assign insn_a = ((cur_pc - lc4_pkg::RESET_PC) < IMEM_SIZE) ?
                    imem[cur_pc - lc4_pkg::RESET_PC] : 16'h0000;
    assign insn_b = ((cur_pc + 16'd1 - lc4_pkg::RESET_PC) < IMEM_SIZE) ?
                    imem[cur_pc + 16'd1 - lc4_pkg::RESET_PC] : 16'h0000;

    lc4_core dut0 (
        .gwe      (gwe),
        .i_rst    (i_rst),
        .i_insn_a (insn_a),
        .i_insn_b (insn_b),
        .o_cur_pc (cur_pc),
        .o_retire (retire)
    );

    function automatic logic [15:0] rrr(input logic [3:0] opc, input int rd, input int rs,
                                        input logic [2:0] sub, input int rt);
        return {opc, rd[2:0], rs[2:0], sub, rt[2:0]};
    endfunction

    function automatic logic [15:0] imm(input logic [3:0] opc, input int rd, input int rs,
                                        input int val);
        return {opc, rd[2:0], rs[2:0], 1'b1, val[4:0]};
    endfunction

    function automatic logic [15:0] cnst(input int rd, input int val);
        return {4'h9, rd[2:0], val[8:0]};
    endfunction

    task automatic add_row(input logic [15:0] insn);
        stim_insn[num_rows] = insn;
        num_rows++;
    endtask

    task automatic open_test(input int t, input string name);
        test_first[t] = num_rows;
        test_name[t]  = name;
    endtask

    task automatic close_test(input int t);
        test_len[t] = num_rows - test_first[t];
    endtask

    // run the reference model over one test in program order
    task automatic fill_expected(input int t);
        logic [15:0] regs [8];
        logic [15:0] insn;
        logic [15:0] next_insn;
        logic [15:0] v;
        logic        lane;
        int          last;
        last = test_first[t] + test_len[t];
        lane = 1'b0;
        for (int r = 0; r < 8; r++) regs[r] = 16'h0;
        for (int i = test_first[t]; i < last; i++) begin
            insn        = stim_insn[i];
            exp_we[i]   = model_writes(insn);
            exp_rd[i]   = insn[11:9];
            v           = model_result(insn, regs[insn[8:6]], regs[insn[2:0]]);
            exp_data[i] = v;
            exp_nzp[i]  = model_nzp(v);
            exp_lane[i] = lane;
            if (exp_we[i]) regs[insn[11:9]] = v;
            // an older slot pairs with the next row unless that row reads its result
            next_insn = (i + 1 < last) ? stim_insn[i + 1] : 16'h0000;
            if (!lane && !(exp_we[i] && model_reads(next_insn, insn[11:9]))) begin
                lane = 1'b1;
            end else begin
                lane = 1'b0;
            end
        end
    endtask

    task automatic build_tables();
        logic [31:0] seed;
        int          k;
        seed = 32'd91424;
        open_test(0, "independent pairs");
        add_row(cnst(1, 5));
        add_row(cnst(2, -3));
        add_row(rrr(4'h1, 3, 1, 3'd0, 2));
        add_row(rrr(4'h1, 4, 1, 3'd2, 2));
        add_row(rrr(4'h1, 5, 1, 3'd1, 2));
        add_row(imm(4'h1, 6, 1, -7));
        add_row(rrr(4'h5, 7, 1, 3'd0, 2));
        add_row(rrr(4'h5, 0, 2, 3'd1, 0));
        add_row(rrr(4'h5, 3, 1, 3'd2, 2));
        add_row(rrr(4'h5, 4, 1, 3'd3, 2));
        add_row(imm(4'h5, 5, 2, 12));
        add_row(cnst(6, -256));
        close_test(0);
        open_test(1, "pair split");
        add_row(cnst(1, 7));
        add_row(rrr(4'h1, 2, 1, 3'd0, 1));
        add_row(rrr(4'h1, 3, 2, 3'd2, 1));
        add_row(rrr(4'h1, 4, 3, 3'd1, 3));
        add_row(cnst(5, 3));
        add_row(imm(4'h1, 6, 5, -1));
        add_row(rrr(4'h5, 7, 1, 3'd3, 5));
        add_row(rrr(4'h5, 0, 6, 3'd2, 7));
        close_test(1);
        open_test(2, "bypass and same destination");
        add_row(cnst(1, 10));
        add_row(cnst(2, 20));
        add_row(rrr(4'h1, 3, 1, 3'd0, 2));
        add_row(rrr(4'h1, 4, 2, 3'd2, 1));
        add_row(cnst(5, 1));
        add_row(cnst(5, 2));
        add_row(rrr(4'h1, 6, 5, 3'd0, 5));
        add_row(rrr(4'h5, 7, 5, 3'd1, 0));
        add_row(rrr(4'h5, 0, 6, 3'd0, 7));
        add_row(imm(4'h1, 1, 5, -16));
        close_test(2);
        open_test(3, "nop and unsupported");
        add_row(cnst(1, -1));
        add_row(16'h0000);
        add_row(rrr(4'h1, 2, 1, 3'd3, 1));
        add_row(16'h0E05);
        add_row(cnst(3, 4));
        add_row(16'hC1C0);
        add_row(16'hD000);
        add_row(rrr(4'h1, 4, 1, 3'd0, 3));
        add_row(16'hA000);
        add_row(rrr(4'h1, 2, 2, 3'd0, 4));
        close_test(3);
        open_test(4, "random program");
        for (int i = 0; i < 200; i++) begin
            seed = xorshift32(seed);
            k    = int'(seed[31:24]) % 10;
            case (k)
                0: add_row(rrr(4'h1, seed[2:0], seed[5:3], 3'd0, seed[8:6]));
                1: add_row(rrr(4'h1, seed[2:0], seed[5:3], 3'd1, seed[8:6]));
                2: add_row(rrr(4'h1, seed[2:0], seed[5:3], 3'd2, seed[8:6]));
                3: add_row(imm(4'h1, seed[2:0], seed[5:3], seed[13:9]));
                4: add_row(rrr(4'h5, seed[2:0], seed[5:3], 3'd0, seed[8:6]));
                5: add_row(rrr(4'h5, seed[2:0], seed[5:3], 3'd1, seed[8:6]));
                6: add_row(rrr(4'h5, seed[2:0], seed[5:3], 3'd2, seed[8:6]));
                7: add_row(rrr(4'h5, seed[2:0], seed[5:3], 3'd3, seed[8:6]));
                8: add_row(imm(4'h5, seed[2:0], seed[5:3], seed[13:9]));
                default: add_row(cnst(seed[2:0], seed[22:14]));
            endcase
        end
        close_test(4);
        for (int t = 0; t < NUM_TESTS; t++) fill_expected(t);
        cycle_limit = 3 * num_rows + 40;
    endtask

    task automatic apply_reset();
        @(posedge gwe);
        rst_q <= 1'b1;
        repeat (3) @(posedge gwe);
        rst_q <= 1'b0;
    endtask

    task automatic check_value(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", sig, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_no_retire();
        checks++;
        assert (!retire[0].valid && !retire[1].valid && !retire[0].we && !retire[1].we)
        else begin
            $display("a retire record was valid or writing too soon after reset");
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        int row;
        int got;
        test_errors = 0;
        for (int i = 0; i < IMEM_SIZE; i++) imem[i] = 16'h0000;
        for (int i = 0; i < test_len[t]; i++) imem[i] = stim_insn[test_first[t] + i];
        apply_reset();
        @(negedge gwe);
        check_value("o_cur_pc", cur_pc, lc4_pkg::RESET_PC);
        check_no_retire();
        repeat (2) begin
            @(negedge gwe);
            check_no_retire();
        end
        got = 0;
        while (got < test_len[t]) begin
            @(negedge gwe);
            for (int l = 0; l < 2; l++) begin           // lane A is older
                if (retire[l].valid && got < test_len[t]) begin
                    row = test_first[t] + got;
                    check_value($sformatf("o_retire[%0d].pc", l), retire[l].pc,
                                lc4_pkg::RESET_PC + 16'(got));
                    check_value($sformatf("o_retire[%0d].insn", l), retire[l].insn,
                                stim_insn[row]);
                    check_value($sformatf("o_retire[%0d] lane", l), 16'(l),
                                16'(exp_lane[row]));
                    check_value($sformatf("o_retire[%0d].we", l), 16'(retire[l].we),
                                16'(exp_we[row]));
                    if (exp_we[row]) begin
                        check_value($sformatf("o_retire[%0d].wsel", l),
                                    16'(retire[l].wsel), 16'(exp_rd[row]));
                        check_value($sformatf("o_retire[%0d].data", l),
                                    retire[l].data, exp_data[row]);
                        check_value($sformatf("o_retire[%0d].nzp", l),
                                    16'(retire[l].nzp), 16'(exp_nzp[row]));
                    end
                    got++;
                end
            end
        end
        $display("test %0d %s: %0d records, %0d errors", t, test_name[t], got, test_errors);
    endtask

    always @(posedge gwe) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the core stopped retiring", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        build_tables();
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+tb
logic/lc4_pkg.sv
logic/lc4_alu.sv
logic/lc4_issue.sv
logic/lc4_lane.sv
logic/lc4_regfile.sv
logic/lc4_core.sv
tb/tb_clock.sv
tb/lc4_core_tb.sv

/* Bender.yml */
package:
  name: lc4_core

sources:
  - logic/lc4_pkg.sv
  - logic/lc4_alu.sv
  - logic/lc4_issue.sv
  - logic/lc4_lane.sv
  - logic/lc4_regfile.sv
  - logic/lc4_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_clock.sv
      - tb/lc4_core_tb.sv
